/* include/ps2_defines.svh */
`ifndef PS2_DEFINES_SVH
`define PS2_DEFINES_SVH

// ========================================
// port count and port index width
// ========================================
`define PS2_NUM_PORTS 2
`define PS2_PORT_W 1

// equal clock samples before the filtered level flips
`define PS2_FILTER_LEN 8

// host hold time on the clock line before request-to-send
`define PS2_INHIBIT_CYCLES 64

// wishbone word offsets
`define PS2_REG_CMD 2'd0
`define PS2_REG_STATUS 2'd1
`define PS2_REG_RXDATA 2'd2

`endif

/* source/ps2_pkg.sv */
`default_nettype none

`include "ps2_defines.svh"

package ps2_pkg;

   // data byte on the ps2 wire
   typedef logic [7:0] ps2_byte_t;
   // index of one port
   typedef logic [`PS2_PORT_W-1:0] ps2_port_idx_t;

   // wishbone data and word address
   typedef logic [31:0] wb_data_t;
   typedef logic [1:0] wb_adr_t;

   // receiver FSM
   typedef enum logic [1:0] {RX_IDLE, RX_DATA, RX_PARITY, RX_STOP} ps2_rx_state_t;

   // transmitter FSM, inhibit and request come before the bits
   typedef enum logic [2:0] {
      TX_IDLE, TX_INHIBIT, TX_REQUEST, TX_DATA, TX_PARITY, TX_STOP, TX_ACK
   } ps2_tx_state_t;

endpackage

`default_nettype wire

/* source/ps2_chan_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ps2_chan_if
   import ps2_pkg::*;
();

   // command path, register block to port
   ps2_byte_t cmd_byte;
   logic      cmd_valid;
   logic      tx_busy;

   // receive path, port to arbiter
   ps2_byte_t rx_byte;
   logic      rx_err;
   logic      rx_valid;
   logic      rx_ack;

   modport regs (output cmd_byte, output cmd_valid, input tx_busy);

   modport port (
      input  cmd_byte, input cmd_valid, output tx_busy,
      output rx_byte, output rx_err, output rx_valid, input rx_ack
   );

   modport arb (input rx_byte, input rx_err, input rx_valid, output rx_ack);

endinterface

`default_nettype wire

/* source/ps2_line_filter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_defines.svh"

module ps2_line_filter (
   input  logic clk,
   input  logic rst,
   input  logic line_in,
   output logic filtered,
   output logic fall_tick
);

   // newest sample enters at the top
   logic [`PS2_FILTER_LEN-1:0] filt_q;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         // idle line is high
         filt_q   <= '1;
         filtered <= 1'b1;
      end
      else
      begin
         filt_q <= {line_in, filt_q[`PS2_FILTER_LEN-1:1]};
         // level changes only on a full run of equal samples
         if (&filt_q)
            filtered <= 1'b1;
         else if (~|filt_q)
            filtered <= 1'b0;
      end
   end

   // high in the cycle before filtered drops
   assign fall_tick = filtered & ~|filt_q;

endmodule

`default_nettype wire

/* source/ps2_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_defines.svh"

module ps2_port
   import ps2_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     ps2_clk_in,
   input  logic     ps2_dat_in,
   output logic     ps2_clk_oe,
   output logic     ps2_dat_oe,
   ps2_chan_if.port chan
);

   logic          clk_filt;
   logic          fall_tick;
   logic [1:0]    dat_sync;
   logic          dat_s;
   logic          tx_busy;
   logic          stop_take;
   // receive side
   ps2_rx_state_t rx_state;
   logic [2:0]    rx_cnt;
   ps2_byte_t     rx_shift;
   logic          rx_par;
   logic          rx_valid;
   ps2_byte_t     rx_byte;
   logic          rx_err;
   // transmit side
   ps2_tx_state_t tx_state;
   logic [$clog2(`PS2_INHIBIT_CYCLES)-1:0] inh_cnt;
   logic [2:0]    tx_cnt;
   ps2_byte_t     tx_shift;
   logic          tx_par;
   logic          tx_acked;

   ps2_line_filter i_clk_filter (
      .clk       (clk),
      .rst       (rst),
      .line_in   (ps2_clk_in),
      .filtered  (clk_filt),
      .fall_tick (fall_tick)
   );

   // data line into the clock domain
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dat_sync <= 2'b11;
      else
         dat_sync <= {dat_sync[0], ps2_dat_in};
   end
   assign dat_s = dat_sync[1];

   // ========================================
   // receiver
   // ========================================
   // stop bit seen with the slot free
   assign stop_take = fall_tick && !tx_busy && (rx_state == RX_STOP) && !rx_valid;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rx_state <= RX_IDLE;
         rx_cnt   <= '0;
         rx_valid <= 1'b0;
      end
      else
      begin
         // arbiter took the byte
         if (chan.rx_ack)
            rx_valid <= 1'b0;
         if (stop_take)
            rx_valid <= 1'b1;
         // receiver parked while a command goes out
         if (tx_busy)
            rx_state <= RX_IDLE;
         else if (fall_tick)
         begin
            case (rx_state)
               RX_IDLE:
               begin
                  // low start bit
                  if (!dat_s)
                  begin
                     rx_cnt   <= '0;
                     rx_state <= RX_DATA;
                  end
               end
               RX_DATA:
               begin
                  rx_cnt <= rx_cnt + 3'd1;
                  if (rx_cnt == 3'd7)
                     rx_state <= RX_PARITY;
               end
               RX_PARITY:
                  rx_state <= RX_STOP;
               default:
                  rx_state <= RX_IDLE;
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      // lsb first, shift down
      if (fall_tick && !tx_busy && (rx_state == RX_DATA))
         rx_shift <= {dat_s, rx_shift[7:1]};
      if (fall_tick && !tx_busy && (rx_state == RX_PARITY))
         rx_par <= dat_s;
      if (stop_take)
      begin
         rx_byte <= rx_shift;
         // odd parity over data and parity bit
         rx_err  <= ~^{rx_shift, rx_par};
      end
   end

   // ========================================
   // transmitter
   // ========================================
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         tx_state   <= TX_IDLE;
         inh_cnt    <= '0;
         tx_cnt     <= '0;
         tx_acked   <= 1'b0;
         ps2_clk_oe <= 1'b0;
         ps2_dat_oe <= 1'b0;
      end
      else
      begin
         case (tx_state)
            TX_IDLE:
            begin
               if (chan.cmd_valid)
               begin
                  // pull clock low to inhibit the device
                  ps2_clk_oe <= 1'b1;
                  inh_cnt    <= '0;
                  tx_state   <= TX_INHIBIT;
               end
            end
            TX_INHIBIT:
            begin
               inh_cnt <= inh_cnt + 1'b1;
               if (inh_cnt == $bits(inh_cnt)'(`PS2_INHIBIT_CYCLES - 1))
               begin
                  // request to send, start bit low and clock released
                  ps2_clk_oe <= 1'b0;
                  ps2_dat_oe <= 1'b1;
                  tx_state   <= TX_REQUEST;
               end
            end
            TX_REQUEST:
            begin
               // first device clock, bit 0 goes out
               if (fall_tick)
               begin
                  ps2_dat_oe <= ~tx_shift[0];
                  tx_cnt     <= 3'd1;
                  tx_state   <= TX_DATA;
               end
            end
            TX_DATA:
            begin
               if (fall_tick)
               begin
                  ps2_dat_oe <= ~tx_shift[0];
                  tx_cnt     <= tx_cnt + 3'd1;
                  if (tx_cnt == 3'd7)
                     tx_state <= TX_PARITY;
               end
            end
            TX_PARITY:
            begin
               if (fall_tick)
               begin
                  ps2_dat_oe <= ~tx_par;
                  tx_state   <= TX_STOP;
               end
            end
            TX_STOP:
            begin
               // stop bit is the released line
               if (fall_tick)
               begin
                  ps2_dat_oe <= 1'b0;
                  tx_state   <= TX_ACK;
               end
            end
            TX_ACK:
            begin
               // device pulls data low for the ack
               if (fall_tick && !dat_s)
                  tx_acked <= 1'b1;
               // done once the device lets both lines go
               if (tx_acked && clk_filt && dat_s)
               begin
                  tx_acked <= 1'b0;
                  tx_state <= TX_IDLE;
               end
            end
            default:
               tx_state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if ((tx_state == TX_IDLE) && chan.cmd_valid)
      begin
         tx_shift <= chan.cmd_byte;
         tx_par   <= ~^chan.cmd_byte;
      end
      else if (fall_tick && ((tx_state == TX_REQUEST) || (tx_state == TX_DATA)))
         tx_shift <= {1'b0, tx_shift[7:1]};
   end

   assign tx_busy       = (tx_state != TX_IDLE);
   assign chan.tx_busy  = tx_busy;
   assign chan.rx_valid = rx_valid;
   assign chan.rx_byte  = rx_byte;
   assign chan.rx_err   = rx_err;

endmodule

`default_nettype wire

/* source/ps2_wb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_defines.svh"

module ps2_wb_regs
   import ps2_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          cyc,
   input  logic          stb,
   input  logic          we,
   input  wb_adr_t       adr,
   input  wb_data_t      dat_w,
   output wb_data_t      dat_r,
   output logic          ack,
   ps2_chan_if.regs      chan [`PS2_NUM_PORTS],
   input  logic          hold_valid,
   input  logic          hold_err,
   input  ps2_byte_t     hold_byte,
   input  ps2_port_idx_t hold_port,
   output logic          pop
);

   logic [`PS2_NUM_PORTS-1:0] busy_vec;
   logic [`PS2_NUM_PORTS-1:0] cmd_valid_q;
   ps2_byte_t                 cmd_byte_q;
   logic                      req;
   logic                      wr_cmd;
   logic                      rd_rx;
   wb_data_t                  rd_word;

   // new classic cycle, not yet acknowledged
   assign req    = cyc && stb && !ack;
   assign wr_cmd = req && we && (adr == `PS2_REG_CMD);
   assign rd_rx  = req && !we && (adr == `PS2_REG_RXDATA);

   for (genvar i = 0; i < `PS2_NUM_PORTS; i++)
   begin : g_chan
      assign busy_vec[i]       = chan[i].tx_busy;
      assign chan[i].cmd_valid = cmd_valid_q[i];
      assign chan[i].cmd_byte  = cmd_byte_q;
   end

   // ========================================
   // read word
   // ========================================
   always_comb
   begin
      rd_word = '0;
      case (adr)
         `PS2_REG_STATUS:
         begin
            rd_word[0]                     = hold_valid;
            rd_word[8 +: `PS2_NUM_PORTS]   = busy_vec;
         end
         `PS2_REG_RXDATA:
         begin
            // empty register reads as all zero
            if (hold_valid)
            begin
               rd_word[7:0]                = hold_byte;
               rd_word[8 +: `PS2_PORT_W]   = hold_port;
               rd_word[16]                 = hold_err;
               rd_word[31]                 = 1'b1;
            end
         end
         default:
            rd_word = '0;
      endcase
   end

   // ========================================
   // ack, pop and command strobes
   // ========================================
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ack         <= 1'b0;
         pop         <= 1'b0;
         cmd_valid_q <= '0;
      end
      else
      begin
         ack <= req;
         // pop only what was actually returned
         pop <= rd_rx && hold_valid;
         for (int p = 0; p < `PS2_NUM_PORTS; p++)
         begin
            // busy port drops the command silently
            cmd_valid_q[p] <= wr_cmd && (dat_w[15:8] == 8'(p)) && !busy_vec[p];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_cmd)
         cmd_byte_q <= dat_w[7:0];
      if (req && !we)
         dat_r <= rd_word;
   end

endmodule

`default_nettype wire

/* source/ps2_rx_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_defines.svh"

module ps2_rx_arbiter
   import ps2_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   ps2_chan_if.arb       chan [`PS2_NUM_PORTS],
   input  logic          pop,
   output logic          hold_valid,
   output logic          hold_err,
   output ps2_byte_t     hold_byte,
   output ps2_port_idx_t hold_port
);

   ps2_port_idx_t             ptr;
   logic [`PS2_NUM_PORTS-1:0] valid_vec;
   logic [`PS2_NUM_PORTS-1:0] err_vec;
   logic [`PS2_NUM_PORTS-1:0] ack_vec;
   ps2_byte_t                 byte_arr [`PS2_NUM_PORTS];
   logic                      take;

   for (genvar i = 0; i < `PS2_NUM_PORTS; i++)
   begin : g_chan
      assign valid_vec[i]   = chan[i].rx_valid;
      assign err_vec[i]     = chan[i].rx_err;
      assign byte_arr[i]    = chan[i].rx_byte;
      assign chan[i].rx_ack = ack_vec[i];
   end

   // one port looked at per clock, only into an empty holder
   assign take = !hold_valid && valid_vec[ptr];

   always_comb
   begin
      ack_vec      = '0;
      ack_vec[ptr] = take;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ptr        <= '0;
         hold_valid <= 1'b0;
      end
      else
      begin
         // pointer walks every clock
         if (ptr == ps2_port_idx_t'(`PS2_NUM_PORTS - 1))
            ptr <= '0;
         else
            ptr <= ptr + 1'b1;
         if (take)
            hold_valid <= 1'b1;
         else if (pop)
            hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         hold_byte <= byte_arr[ptr];
         hold_port <= ptr;
         hold_err  <= err_vec[ptr];
      end
   end

endmodule

`default_nettype wire

/* source/ps2_host_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_defines.svh"

module ps2_host_top
   import ps2_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      cyc,
   input  logic                      stb,
   input  logic                      we,
   input  wb_adr_t                   adr,
   input  wb_data_t                  dat_w,
   output wb_data_t                  dat_r,
   output logic                      ack,
   input  logic [`PS2_NUM_PORTS-1:0] ps2_clk_in,
   input  logic [`PS2_NUM_PORTS-1:0] ps2_dat_in,
   output logic [`PS2_NUM_PORTS-1:0] ps2_clk_oe,
   output logic [`PS2_NUM_PORTS-1:0] ps2_dat_oe
);

   // holding register to register block
   logic          hold_valid;
   logic          hold_err;
   ps2_byte_t     hold_byte;
   ps2_port_idx_t hold_port;
   logic          pop;

   // one channel bundle per port
   ps2_chan_if chan [`PS2_NUM_PORTS] ();

   // ========================================
   // ports
   // ========================================
   for (genvar i = 0; i < `PS2_NUM_PORTS; i++)
   begin : g_port
      ps2_port i_port (
         .clk        (clk),
         .rst        (rst),
         .ps2_clk_in (ps2_clk_in[i]),
         .ps2_dat_in (ps2_dat_in[i]),
         .ps2_clk_oe (ps2_clk_oe[i]),
         .ps2_dat_oe (ps2_dat_oe[i]),
         .chan       (chan[i])
      );
   end

   ps2_wb_regs i_regs (
      .clk        (clk),
      .rst        (rst),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .dat_r      (dat_r),
      .ack        (ack),
      .chan       (chan),
      .hold_valid (hold_valid),
      .hold_err   (hold_err),
      .hold_byte  (hold_byte),
      .hold_port  (hold_port),
      .pop        (pop)
   );

   ps2_rx_arbiter i_arb (
      .clk        (clk),
      .rst        (rst),
      .chan       (chan),
      .pop        (pop),
      .hold_valid (hold_valid),
      .hold_err   (hold_err),
      .hold_byte  (hold_byte),
      .hold_port  (hold_port)
   );

endmodule

`default_nettype wire

/* tb/ps2_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module ps2_clk_gen (
   output logic clk,
   output logic rst
);

   // 4 ns period, falling edges on multiples of 4 ns
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // reset held for 8 cycles, released on a falling edge
   initial
   begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

/* tb/ps2_host_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_defines.svh"

module ps2_host_asserts (
   input logic                      clk,
   input logic                      rst,
   input logic                      cyc,
   input logic                      stb,
   input logic                      ack,
   input logic [`PS2_NUM_PORTS-1:0] tx_busy,
   input logic [`PS2_NUM_PORTS-1:0] ps2_clk_oe,
   input logic [`PS2_NUM_PORTS-1:0] ps2_dat_oe
);

   // failed assertions so far, read by the testbench at the end
   int fail_count = 0;

   // ========================================
   // wishbone
   // ========================================
   ack_after_req: assert property (@(posedge clk) disable iff (rst)
      ack |-> $past(cyc && stb))
   else
   begin
      fail_count++;
      $error("ack raised without cyc and stb");
   end

   ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
      ack |=> !ack)
   else
   begin
      fail_count++;
      $error("ack held for two cycles");
   end

   // ========================================
   // lines
   // ========================================
   for (genvar i = 0; i < `PS2_NUM_PORTS; i++)
   begin : g_line
      // clock pulled only by a transmitting port
      clk_oe_busy: assert property (@(posedge clk) disable iff (rst)
         ps2_clk_oe[i] |-> tx_busy[i])
      else
      begin
         fail_count++;
         $error("clock output enable high on an idle port");
      end
   end

   oe_low_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> (ps2_clk_oe == '0) && (ps2_dat_oe == '0))
   else
   begin
      fail_count++;
      $error("output enable high after reset");
   end

endmodule

// busy flags taken from the register block
bind ps2_host_top ps2_host_asserts i_asserts (
   .clk        (clk),
   .rst        (rst),
   .cyc        (cyc),
   .stb        (stb),
   .ack        (ack),
   .tx_busy    (i_regs.busy_vec),
   .ps2_clk_oe (ps2_clk_oe),
   .ps2_dat_oe (ps2_dat_oe)
);

`default_nettype wire

/* tb/ps2_host_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_defines.svh"

module ps2_host_tb
   import ps2_pkg::*;
();

   // table operations
   localparam logic [1:0] OP_SEND     = 2'd0;
   localparam logic [1:0] OP_DRAIN    = 2'd1;
   localparam logic [1:0] OP_CMD      = 2'd2;
   localparam logic [1:0] OP_CMD_BUSY = 2'd3;

   localparam int N_ROWS = 16;
   // worst frame, inhibit plus 12 device clocks of 80 ns
   localparam int FRAME_CYCLES   = `PS2_INHIBIT_CYCLES + 12 * 80 / 4;
   localparam int TIMEOUT_CYCLES = N_ROWS * 2 * FRAME_CYCLES;
   localparam int POLL_LIMIT     = 64;

   typedef struct packed {
      logic [1:0] op;
      logic [7:0] port;
      ps2_byte_t  data;
      logic       bad;
      logic       rnd;
   } row_t;

   logic                      clk;
   logic                      rst;
   logic                      cyc;
   logic                      stb;
   logic                      we;
   wb_adr_t                   adr;
   wb_data_t                  dat_w;
   wb_data_t                  dat_r;
   logic                      ack;
   logic [`PS2_NUM_PORTS-1:0] clk_oe;
   logic [`PS2_NUM_PORTS-1:0] dat_oe;
   // device side pulls
   logic [`PS2_NUM_PORTS-1:0] dev_clk_pull;
   logic [`PS2_NUM_PORTS-1:0] dev_dat_pull;
   wire  [`PS2_NUM_PORTS-1:0] line_clk;
   wire  [`PS2_NUM_PORTS-1:0] line_dat;

   row_t      rows [N_ROWS];
   logic      exp_pend [`PS2_NUM_PORTS];
   ps2_byte_t exp_byte [`PS2_NUM_PORTS];
   logic      exp_err [`PS2_NUM_PORTS];
   int        pending;
   logic [15:0] lfsr;
   int        cycles;
   wb_data_t  word;

   // open drain, low when either side pulls
   assign line_clk = ~(clk_oe | dev_clk_pull);
   assign line_dat = ~(dat_oe | dev_dat_pull);

   ps2_clk_gen i_clk_gen (
      .clk (clk),
      .rst (rst)
   );

   ps2_host_top i_dut (
      .clk        (clk),
      .rst        (rst),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .dat_r      (dat_r),
      .ack        (ack),
      .ps2_clk_in (line_clk),
      .ps2_dat_in (line_dat),
      .ps2_clk_oe (clk_oe),
      .ps2_dat_oe (dat_oe)
   );

   // ========================================
   // checking and helpers
   // ========================================
   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("ERROR %s expected 0x%08h actual 0x%08h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "run stopped");
   endtask

   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one lfsr step per bit
   task automatic rand_byte(output ps2_byte_t b);
      for (int i = 0; i < 8; i++)
      begin
         lfsr = lfsr_next(lfsr);
         b[i] = lfsr[0];
      end
   endtask

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
      begin
         $display("timeout: run went past %0d clock cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $fatal(1, "timeout");
      end
   end

   // one classic cycle, driven on falling edges
   task automatic bus_cycle(input logic write, input wb_adr_t a, input wb_data_t wd,
                            output wb_data_t rd);
      int waits;
      waits = 0;
      @(negedge clk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = a;
      dat_w = wd;
      @(negedge clk);
      while (!ack)
      begin
         waits++;
         if (waits > 8)
            abort_run("wishbone cycle was never acknowledged");
         @(negedge clk);
      end
      rd  = dat_r;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   // ========================================
   // device models
   // ========================================
   // start, 8 data lsb first, parity, stop
   task automatic send_frame(input int p, input ps2_byte_t b, input logic bad);
      logic       par;
      logic [10:0] frame;
      par   = bad ? ^b : ~^b;
      frame = {1'b1, par, b, 1'b0};
      @(negedge clk);
      for (int i = 0; i < 11; i++)
      begin
         // data moves while the clock is high
         dev_dat_pull[p] = ~frame[i];
         #20;
         dev_clk_pull[p] = 1'b1;
         #40;
         dev_clk_pull[p] = 1'b0;
         #20;
      end
      dev_dat_pull[p] = 1'b0;
      #40;
   endtask

   // host request, 10 clocked bits, then the ack
   task automatic dev_recv(input int p, output ps2_byte_t b, output logic par,
                           output logic stop);
      logic [9:0] bits;
      // clock released with data low
      while (!(line_clk[p] && !line_dat[p]))
         @(negedge clk);
      #80;
      for (int k = 0; k < 10; k++)
      begin
         dev_clk_pull[p] = 1'b1;
         #40;
         dev_clk_pull[p] = 1'b0;
         #40;
         // sampled at the end of the high phase
         bits[k] = line_dat[p];
      end
      dev_dat_pull[p] = 1'b1;
      #20;
      dev_clk_pull[p] = 1'b1;
      #40;
      dev_clk_pull[p] = 1'b0;
      #40;
      dev_dat_pull[p] = 1'b0;
      #40;
      b    = bits[7:0];
      par  = bits[8];
      stop = bits[9];
   endtask

   // ========================================
   // row handling
   // ========================================
   // every outstanding frame once, any order
   task automatic drain_rx(input string tag);
      wb_data_t w;
      int       p;
      int       polls;
      polls = 0;
      while (pending > 0)
      begin
         bus_cycle(1'b0, `PS2_REG_RXDATA, '0, w);
         if (w[31])
         begin
            p = int'(w[15:8]);
            if (p >= `PS2_NUM_PORTS || !exp_pend[p])
               abort_run("byte read from a port with no frame outstanding");
            check($sformatf("%s rxdata port %0d", tag, p),
                  {1'b1, 14'h0, exp_err[p], 8'(p), exp_byte[p]}, w);
            exp_pend[p] = 1'b0;
            pending--;
         end
         else
         begin
            polls++;
            if (polls > POLL_LIMIT)
               abort_run("received byte never showed up in RXDATA");
            repeat (4) @(negedge clk);
         end
      end
      bus_cycle(1'b0, `PS2_REG_RXDATA, '0, w);
      check({tag, " rxdata empty"}, 32'h0, w[31]);
   endtask

   task automatic wait_idle(input int p, input string tag);
      wb_data_t w;
      int       polls;
      polls = 0;
      bus_cycle(1'b0, `PS2_REG_STATUS, '0, w);
      while (w[8 + p])
      begin
         polls++;
         if (polls > POLL_LIMIT)
            abort_run("port stayed busy after the device ack");
         bus_cycle(1'b0, `PS2_REG_STATUS, '0, w);
      end
      // nothing received and no other port busy
      check({tag, " status idle"}, 32'h0, w);
   endtask

   task automatic apply_row(input int r, input row_t row);
      ps2_byte_t data;
      ps2_byte_t got;
      logic      par;
      logic      stop;
      wb_data_t  w;
      int        p;
      string     tag;
      data = row.data;
      if (row.rnd)
         rand_byte(data);
      p   = int'(row.port);
      tag = $sformatf("row %0d", r);
      case (row.op)
         OP_SEND:
         begin
            send_frame(p, data, row.bad);
            exp_pend[p] = 1'b1;
            exp_byte[p] = data;
            exp_err[p]  = row.bad;
            pending++;
         end
         OP_DRAIN:
            drain_rx(tag);
         default:
         begin
            bus_cycle(1'b1, `PS2_REG_CMD, {16'h0, row.port, data}, w);
            // second command lands on a busy port
            if (row.op == OP_CMD_BUSY)
               bus_cycle(1'b1, `PS2_REG_CMD, {16'h0, row.port, ~data}, w);
            fork
               dev_recv(p, got, par, stop);
               begin
                  bus_cycle(1'b0, `PS2_REG_STATUS, '0, w);
                  check({tag, " busy set"}, 32'h1, w[8 + p]);
               end
            join
            check({tag, " cmd byte"}, data, got);
            // odd count of ones over byte and parity
            check({tag, " cmd parity"}, 32'h1, ^{got, par});
            check({tag, " cmd stop"}, 32'h1, stop);
            wait_idle(p, tag);
            if (row.op == OP_CMD_BUSY)
            begin
               repeat (2 * `PS2_INHIBIT_CYCLES) @(negedge clk);
               bus_cycle(1'b0, `PS2_REG_STATUS, '0, w);
               check({tag, " dropped cmd"}, 32'h0, w);
            end
         end
      endcase
   endtask

   // op, port, byte, bad parity, random byte
   task automatic load_table();
      rows[0]  = {OP_SEND,     8'd0, 8'h5a, 1'b0, 1'b0};
      rows[1]  = {OP_DRAIN,    8'd0, 8'h00, 1'b0, 1'b0};
      rows[2]  = {OP_SEND,     8'd1, 8'hc3, 1'b0, 1'b0};
      rows[3]  = {OP_DRAIN,    8'd0, 8'h00, 1'b0, 1'b0};
      rows[4]  = {OP_SEND,     8'd0, 8'h81, 1'b1, 1'b0};
      rows[5]  = {OP_DRAIN,    8'd0, 8'h00, 1'b0, 1'b0};
      // two ports complete before the read
      rows[6]  = {OP_SEND,     8'd1, 8'h00, 1'b0, 1'b1};
      rows[7]  = {OP_SEND,     8'd0, 8'h00, 1'b0, 1'b1};
      rows[8]  = {OP_DRAIN,    8'd0, 8'h00, 1'b0, 1'b0};
      rows[9]  = {OP_SEND,     8'd1, 8'h00, 1'b1, 1'b1};
      rows[10] = {OP_DRAIN,    8'd0, 8'h00, 1'b0, 1'b0};
      rows[11] = {OP_CMD,      8'd0, 8'hed, 1'b0, 1'b0};
      rows[12] = {OP_CMD,      8'd1, 8'h00, 1'b0, 1'b1};
      rows[13] = {OP_CMD_BUSY, 8'd1, 8'hf4, 1'b0, 1'b0};
      // receiver alive again after a command
      rows[14] = {OP_SEND,     8'd0, 8'h3c, 1'b0, 1'b0};
      rows[15] = {OP_DRAIN,    8'd0, 8'h00, 1'b0, 1'b0};
   endtask

   // ========================================
   // main sequence
   // ========================================
   initial
   begin
      cyc          = 1'b0;
      stb          = 1'b0;
      we           = 1'b0;
      adr          = '0;
      dat_w        = '0;
      dev_clk_pull = '0;
      dev_dat_pull = '0;
      lfsr         = 16'd69;
      pending      = 0;
      cycles       = 0;
      for (int i = 0; i < `PS2_NUM_PORTS; i++)
         exp_pend[i] = 1'b0;
      load_table();
      wait (rst === 1'b0);
      // idle state right after reset
      bus_cycle(1'b0, `PS2_REG_STATUS, '0, word);
      check("reset status", 32'h0, word);
      bus_cycle(1'b0, `PS2_REG_RXDATA, '0, word);
      check("reset rxdata valid", 32'h0, word[31]);
      for (int r = 0; r < N_ROWS; r++)
         apply_row(r, rows[r]);
      if (i_dut.i_asserts.fail_count == 0)
      begin
         $display("Test passed");
         $finish;
      end
      else
      begin
         $display("Test failed");
         $fatal(1, "assertion failures");
      end
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
source/ps2_pkg.sv
source/ps2_chan_if.sv
source/ps2_line_filter.sv
source/ps2_port.sv
source/ps2_wb_regs.sv
source/ps2_rx_arbiter.sv
source/ps2_host_top.sv
tb/ps2_clk_gen.sv
tb/ps2_host_asserts.sv
tb/ps2_host_tb.sv

/* Bender.yml */
package:
  name: ps2_host

export_include_dirs:
  - include

sources:
  - files:
      - source/ps2_pkg.sv
      - source/ps2_chan_if.sv
      - source/ps2_line_filter.sv
      - source/ps2_port.sv
      - source/ps2_wb_regs.sv
      - source/ps2_rx_arbiter.sv
      - source/ps2_host_top.sv
  - target: test
    files:
      - tb/ps2_clk_gen.sv
      - tb/ps2_host_asserts.sv
      - tb/ps2_host_tb.sv
